//--- sim.f
+incdir+sim
rtl/rip_pkg.sv
rtl/rip_decoder.sv
rtl/rip_operand_fetch.sv
rtl/rip_alu_stage.sv
rtl/rip_exec_core.sv
sim/tb_rip_exec_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_rip_exec_core
FILELIST  := sim.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- sim/tb_rip_model.svh
`ifndef TB_RIP_MODEL_SVH
`define TB_RIP_MODEL_SVH

// reference register file, updated in issue order
logic [31:0] model_regs [32];

function automatic logic [31:0] model_alu(
    input logic [2:0]  f3,
    input logic        alt,
    input logic [31:0] a,
    input logic [31:0] b
);
    logic [31:0] res;
    case (f3)
        3'd0: res = alt ? a - b : a + b;
        3'd1: res = a << b[4:0];
        3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: res = (a < b) ? 32'd1 : 32'd0;
        3'd4: res = a ^ b;
        3'd5: res = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6: res = a | b;
        default: res = a & b;
    endcase
    return res;
endfunction

// executes one word against the model, returns the value and whether it writes
function automatic logic [31:0] model_exec(
    input  logic [31:0] w,
    output logic        wr,
    output logic [4:0]  rd
);
    logic [31:0] a;
    logic [31:0] res;
    a   = (w[19:15] == 5'd0) ? 32'd0 : model_regs[w[19:15]];
    rd  = w[11:7];
    wr  = 1'b1;
    res = 32'd0;
    case (w[6:0])
        7'h33: res = model_alu(w[14:12], w[30],
                               a, (w[24:20] == 5'd0) ? 32'd0 : model_regs[w[24:20]]);
        // SRAI only uses the alt bit
        7'h13: res = model_alu(w[14:12], w[30] && w[14:12] == 3'd5,
                               a, {{20{w[31]}}, w[31:20]});
        7'h37: res = {w[31:12], 12'd0};
        default: wr = 1'b0;
    endcase
    if (rd == 5'd0) begin
        wr = 1'b0;
    end
    if (wr) begin
        model_regs[rd] = res;
    end
    return res;
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'h13};
endfunction

function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'h37};
endfunction

function automatic logic [31:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state;
endfunction

`endif

//--- sim/tb_rip_exec_core.sv
`timescale 1ns/1ps

module tb_rip_exec_core;
    import rip_pkg::*;

    logic  clk;
    logic  rst_n;
    logic  inst_valid;
    inst_u inst_code;
    wb_t   wb;

    `include "tb_rip_model.svh"

    wb_t         exp_q [$];
    time         time_q [$];
    wb_t         exp_head;
    time         t_head;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    logic [31:0] rng;

    rip_exec_core uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_valid(inst_valid),
        .inst_code (inst_code),
        .wb        (wb)
    );

    always #5 clk = ~clk;

    // wb is stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && wb.valid) begin
            assert (exp_q.size() != 0) else begin
                $display("ERROR: unexpected write-back to x%0d, nothing was pending", wb.rd);
                errors++;
            end
            if (exp_q.size() != 0) begin
                exp_head = exp_q.pop_front();
                t_head   = time_q.pop_front();
                assert (wb.rd == exp_head.rd && wb.data == exp_head.data) else begin
                    $display("FAIL wb: rd=%h data=%h, expected rd=%h data=%h",
                             wb.rd, wb.data, exp_head.rd, exp_head.data);
                    errors++;
                end
                // two edges after the strobe
                assert ($time - t_head == 20) else begin
                    $display("ERROR: write-back arrived %0d ns after its strobe", $time - t_head);
                    errors++;
                end
            end
        end
    end

    task automatic issue(input logic [31:0] word);
        logic        wr;
        logic [4:0]  rd;
        logic [31:0] val;
        wb_t         e;
        @(negedge clk);
        inst_valid = 1'b1;
        inst_code  = word;
        val = model_exec(word, wr, rd);
        if (wr) begin
            e.valid = 1'b1;
            e.rd    = rd;
            e.data  = val;
            exp_q.push_back(e);
            time_q.push_back($time);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            inst_valid = 1'b0;
            inst_code  = '0;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        int cycles;
        cycles = 0;
        idle(1);
        while (exp_q.size() != 0 && cycles < 50) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("ERROR: %s timed out with %0d write-backs missing", name, exp_q.size());
            exp_q.delete();
            time_q.delete();
            errors++;
            tests_failed++;
        end
        else if (errors == err_before) begin
            tests_passed++;
            $display("PASS %s", name);
        end
        else begin
            tests_failed++;
            $display("ERR  %s (%0d errors)", name, errors - err_before);
        end
    endtask

    initial begin
        int          e0;
        logic [31:0] r;
        logic [2:0]  f3;
        logic        alt;
        clk          = 1'b0;
        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst_code    = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        rng          = 32'd59524;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        e0 = errors;
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            assert (!wb.valid) else begin
                $display("FAIL wb.valid: %h before any strobe, expected 0", wb.valid);
                errors++;
            end
        end
        finish_test("reset", e0);

        e0 = errors;
        issue(enc_i(-12'sd5, 5'd0, 3'd0, 5'd1));
        issue(enc_i(12'd3, 5'd0, 3'd0, 5'd2));
        issue(enc_lui(20'h80000, 5'd3));
        issue(enc_i(12'd7, 5'd0, 3'd0, 5'd4));
        idle(3);
        for (int k = 0; k < 8; k++) begin
            issue(enc_r(7'h00, 5'd2, 5'd1, k[2:0], 5'd5 + k[4:0]));
            issue(enc_r(7'h00, 5'd4, 5'd3, k[2:0], 5'd13 + k[4:0]));
        end
        issue(enc_r(7'h20, 5'd1, 5'd2, 3'd0, 5'd21));
        issue(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd22));
        issue(enc_r(7'h20, 5'd4, 5'd3, 3'd5, 5'd23));
        finish_test("reg-reg", e0);

        e0 = errors;
        for (int k = 0; k < 8; k++) begin
            if (k == 1 || k == 5) begin
                issue(enc_i(12'd4, 5'd3, k[2:0], 5'd5 + k[4:0]));
            end
            else begin
                issue(enc_i(-12'sd100, 5'd1, k[2:0], 5'd5 + k[4:0]));
            end
        end
        issue(enc_i({7'h20, 5'd4}, 5'd3, 3'd5, 5'd14));
        issue(enc_i(12'h7ff, 5'd3, 3'd3, 5'd15));
        issue(enc_lui(20'hfedcb, 5'd16));
        finish_test("immediate", e0);

        e0 = errors;
        issue(enc_i(12'd1, 5'd0, 3'd0, 5'd11));
        repeat (4) issue(enc_i(12'd1, 5'd11, 3'd0, 5'd11));
        issue(enc_i(12'd10, 5'd0, 3'd0, 5'd12));
        issue(enc_i(12'd20, 5'd0, 3'd0, 5'd13));
        issue(enc_r(7'h00, 5'd12, 5'd12, 3'd0, 5'd14));
        issue(enc_i(12'd30, 5'd0, 3'd0, 5'd15));
        issue(enc_i(12'd1, 5'd0, 3'd0, 5'd16));
        issue(enc_i(12'd2, 5'd0, 3'd0, 5'd17));
        issue(enc_r(7'h20, 5'd11, 5'd15, 3'd0, 5'd18));
        finish_test("forwarding", e0);

        e0 = errors;
        issue(enc_i(12'd5, 5'd0, 3'd0, 5'd0));
        issue(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd20));
        issue(32'h1234_52ff);
        issue(enc_i(12'd9, 5'd1, 3'd0, 5'd0));
        issue(enc_r(7'h00, 5'd0, 5'd0, 3'd6, 5'd19));
        finish_test("x0 and unknown opcode", e0);

        e0 = errors;
        for (int n = 0; n < 300; n++) begin
            r   = lcg_next(rng);
            f3  = r[14:12];
            alt = r[30] && (f3 == 3'd5 || (f3 == 3'd0 && r[2:0] == 3'd0));
            case (r[1:0])
                2'd0: issue(enc_r(alt ? 7'h20 : 7'h00, r[24:20], r[19:15], f3, r[11:7]));
                2'd1: issue((f3 == 3'd1 || f3 == 3'd5)
                            ? enc_i({alt ? 7'h20 : 7'h00, r[24:20]}, r[19:15], f3, r[11:7])
                            : enc_i(r[31:20], r[19:15], f3, r[11:7]));
                2'd2: issue(enc_lui(r[31:12], r[11:7]));
                default: issue(r[3] ? {r[31:7], 7'h7b} : enc_i(r[31:20], r[19:15], f3, r[11:7]));
            endcase
            if (r[27:26] == 2'd0) begin
                idle(1 + r[29:28]);
            end
        end
        finish_test("random mix", e0);

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation passed");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- rtl/rip_exec_core.sv
`timescale 1ns/1ps

module rip_exec_core (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           inst_valid,
    input  rip_pkg::inst_u inst_code,
    output rip_pkg::wb_t   wb
);
    import rip_pkg::*;

    decoded_t  de;
    operands_t ops;
    wb_t       fwd;

    // decode and operand read run side by side on the same word
    rip_decoder decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_valid(inst_valid),
        .inst_code (inst_code),
        .de        (de)
    );

    rip_operand_fetch operand_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_valid(inst_valid),
        .inst_code (inst_code),
        .fwd       (fwd),
        .wb        (wb),
        .ops       (ops)
    );

    rip_alu_stage alu_stage (
        .clk  (clk),
        .rst_n(rst_n),
        .de   (de),
        .ops  (ops),
        .fwd  (fwd),
        .wb   (wb)
    );

endmodule

//--- rtl/rip_alu_stage.sv
`timescale 1ns/1ps

module rip_alu_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  rip_pkg::decoded_t  de,
    input  rip_pkg::operands_t ops,
    output rip_pkg::wb_t       fwd,
    output rip_pkg::wb_t       wb
);
    import rip_pkg::*;

    logic [XLEN-1:0]         op_a;
    logic [XLEN-1:0]         op_b;
    logic [$clog2(XLEN)-1:0] shamt;
    logic [XLEN-1:0]         result;

    assign op_a  = ops.rs1_val;
    assign op_b  = de.use_imm ? de.imm : ops.rs2_val;
    assign shamt = op_b[$clog2(XLEN)-1:0];

    always_comb begin
        case (de.alu_op)
            ALU_ADD: begin
                result = op_a + op_b;
            end
            ALU_SUB: begin
                result = op_a - op_b;
            end
            ALU_SLL: begin
                result = op_a << shamt;
            end
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            end
            ALU_SLTU: begin
                result = {{(XLEN-1){1'b0}}, (op_a < op_b)};
            end
            ALU_XOR: begin
                result = op_a ^ op_b;
            end
            ALU_SRL: begin
                result = op_a >> shamt;
            end
            ALU_SRA: begin
                result = $unsigned($signed(op_a) >>> shamt);
            end
            ALU_OR: begin
                result = op_a | op_b;
            end
            ALU_AND: begin
                result = op_a & op_b;
            end
            ALU_PASS_B: begin
                // LUI
                result = op_b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // result of this cycle, fed back for back-to-back dependencies
    assign fwd.valid = de.valid & de.writes_rd;
    assign fwd.rd    = de.rd;
    assign fwd.data  = result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb <= '0;
        end
        else begin
            wb <= fwd;
        end
    end

endmodule

//--- rtl/rip_operand_fetch.sv
`timescale 1ns/1ps

module rip_operand_fetch (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               inst_valid,
    input  rip_pkg::inst_u     inst_code,
    input  rip_pkg::wb_t       fwd,
    input  rip_pkg::wb_t       wb,
    output rip_pkg::operands_t ops
);
    import rip_pkg::*;

    logic [XLEN-1:0] regfile [NUM_REGS];
    logic [XLEN-1:0] rs1_rf;
    logic [XLEN-1:0] rs2_rf;
    operands_t       ops_next;

    // youngest result wins, then the one being written back
    function automatic logic [XLEN-1:0] bypass(
        input logic [REG_ADDR_W-1:0] rs,
        input logic [XLEN-1:0]       rf_val,
        input wb_t                   fwd_in,
        input wb_t                   wb_in
    );
        logic [XLEN-1:0] val;
        if (fwd_in.valid && fwd_in.rd == rs) begin
            val = fwd_in.data;
        end
        else if (wb_in.valid && wb_in.rd == rs) begin
            val = wb_in.data;
        end
        else begin
            val = rf_val;
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (wb.valid) begin
            regfile[wb.rd] <= wb.data;
        end
    end

    // x0 reads as zero
    assign rs1_rf = (inst_code.r.rs1 == '0) ? '0 : regfile[inst_code.r.rs1];
    assign rs2_rf = (inst_code.r.rs2 == '0) ? '0 : regfile[inst_code.r.rs2];

    always_comb begin
        ops_next.rs1_val = bypass(inst_code.r.rs1, rs1_rf, fwd, wb);
        ops_next.rs2_val = bypass(inst_code.r.rs2, rs2_rf, fwd, wb);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ops <= '0;
        end
        else if (inst_valid) begin
            ops <= ops_next;
        end
    end

endmodule

//--- rtl/rip_decoder.sv
`timescale 1ns/1ps

module rip_decoder (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              inst_valid,
    input  rip_pkg::inst_u    inst_code,
    output rip_pkg::decoded_t de
);
    import rip_pkg::*;

    decoded_t de_next;
    logic     known_op;
    logic     alt;

    function automatic alu_op_e alu_from_funct3(
        input logic [2:0] funct3,
        input logic       alt_sub,
        input logic       alt_sra
    );
        alu_op_e op;
        case (funct3)
            F3_ADD_SUB: op = alt_sub ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SR:      op = alt_sra ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            // F3_AND
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    assign alt = (inst_code.r.funct7 == F7_ALT);

    always_comb begin
        de_next.valid   = inst_valid;
        de_next.rd      = inst_code.r.rd;
        de_next.use_imm = 1'b0;
        de_next.alu_op  = ALU_ADD;
        // sign-extended I-type immediate by default
        de_next.imm     = {{(XLEN-12){inst_code.i.imm12[11]}}, inst_code.i.imm12};
        known_op        = 1'b1;

        case (inst_code.r.opcode)
            OPC_OP: begin
                de_next.alu_op = alu_from_funct3(inst_code.r.funct3, alt, alt);
            end
            OPC_OP_IMM: begin
                de_next.use_imm = 1'b1;
                // no SUBI, only SRAI uses the alt bit
                de_next.alu_op  = alu_from_funct3(inst_code.i.funct3, 1'b0, alt);
                if (inst_code.i.funct3 == F3_SLL || inst_code.i.funct3 == F3_SR) begin
                    de_next.imm = {{(XLEN-5){1'b0}}, inst_code.i.imm12[4:0]};
                end
            end
            OPC_LUI: begin
                de_next.use_imm = 1'b1;
                de_next.alu_op  = ALU_PASS_B;
                de_next.imm     = {inst_code.u.imm20, 12'b0};
            end
            default: begin
                // unknown opcode retires without a write
                known_op = 1'b0;
            end
        endcase

        de_next.writes_rd = known_op && (inst_code.r.rd != '0);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de.valid     <= 1'b0;
            de.writes_rd <= 1'b0;
        end
        else begin
            de <= de_next;
        end
    end

endmodule

//--- rtl/rip_pkg.sv
package rip_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // kept major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // selects SUB and SRA/SRAI
    localparam logic [6:0] F7_ALT = 7'b0100000;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0]           imm20;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        u_fmt_t u;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic                  valid;
        logic                  writes_rd;
        alu_op_e               alu_op;
        logic                  use_imm;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
    } decoded_t;

    typedef struct packed {
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
    } operands_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage
